// File: rtl/opn_reg_pkg.sv
`default_nettype none

package opn_reg_pkg;

    // Host register map, bank 0
    localparam logic [7:0] REG_TA_HI     = 8'h24;  // Timer A bits 9..2
    localparam logic [7:0] REG_TA_LO     = 8'h25;  // Timer A bits 1..0
    localparam logic [7:0] REG_TB        = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL = 8'h27;
    localparam logic [7:0] REG_DIV6      = 8'h2D;  // Address write alone selects
    localparam logic [7:0] REG_DIV3      = 8'h2E;
    localparam logic [7:0] REG_DIV2      = 8'h2F;

    // Timer control register bits
    localparam int CTL_LOAD_A_BIT   = 0;
    localparam int CTL_LOAD_B_BIT   = 1;
    localparam int CTL_IRQ_EN_A_BIT = 2;
    localparam int CTL_IRQ_EN_B_BIT = 3;
    localparam int CTL_CLR_A_BIT    = 4;
    localparam int CTL_CLR_B_BIT    = 5;

    localparam int TA_W        = 10;
    localparam int TA_LO_W     = 2;   // Bits held in REG_TA_LO
    localparam int TB_W        = 8;
    localparam int TB_PRESCALE = 16;  // Zero pulses per timer B step

    // Status byte
    localparam int STATUS_BUSY_BIT   = 7;
    localparam int STATUS_FLAG_A_BIT = 0;
    localparam int STATUS_FLAG_B_BIT = 1;

endpackage

`default_nettype wire

// File: rtl/opn_clk_pkg.sv
`default_nettype none

package opn_clk_pkg;

    localparam int DIV_W = 2;

    // Divider select codes, reset value is divide by 6
    localparam logic [DIV_W-1:0] DIV_SEL_6 = 2'd0;
    localparam logic [DIV_W-1:0] DIV_SEL_3 = 2'd1;
    localparam logic [DIV_W-1:0] DIV_SEL_2 = 2'd2;

    localparam int DIV_RATIO_6 = 6;  // cen pulses per clk_en
    localparam int DIV_RATIO_3 = 3;
    localparam int DIV_RATIO_2 = 2;

    localparam int OPS_PER_CH = 4;

    // Write busy length in clk_en pulses
    localparam int BUSY_TICKS = 32;

endpackage

`default_nettype wire

// File: rtl/timer_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface timer_ctrl_if
    import opn_reg_pkg::*;
();
    logic [TA_W-1:0] value_a;
    logic [TB_W-1:0] value_b;
    logic            load_a;
    logic            load_b;
    logic            irq_en_a;
    logic            irq_en_b;
    logic            clr_a;     // Single-cycle pulse
    logic            clr_b;     // Single-cycle pulse
    logic            flag_a;
    logic            flag_b;

    modport regs (
        output value_a, value_b, load_a, load_b, irq_en_a, irq_en_b, clr_a, clr_b,
        input  flag_a, flag_b
    );

    modport timers (
        input  value_a, value_b, load_a, load_b, irq_en_a, irq_en_b, clr_a, clr_b,
        output flag_a, flag_b
    );
endinterface

`default_nettype wire

// File: rtl/opn_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module opn_clock_gen
    import opn_clk_pkg::*;
#(
    parameter int NUM_CH = 6
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen,
    input  logic [DIV_W-1:0] div_sel,
    output logic             clk_en,
    output logic             zero
);
    localparam int SLOTS   = NUM_CH * OPS_PER_CH;
    localparam int SLOT_W  = $clog2(SLOTS);
    localparam int RATIO_W = $clog2(DIV_RATIO_6 + 1);

    logic [RATIO_W-1:0] cen_cnt;
    logic [RATIO_W-1:0] ratio;     // Divider in force this period
    logic [SLOT_W-1:0]  slot_cnt;
    logic               tick;      // Last cen of the period
    logic               last_slot;

    function automatic logic [RATIO_W-1:0] ratio_of(input logic [DIV_W-1:0] sel);
        case (sel)
            DIV_SEL_6: ratio_of = RATIO_W'(DIV_RATIO_6);
            DIV_SEL_3: ratio_of = RATIO_W'(DIV_RATIO_3);
            DIV_SEL_2: ratio_of = RATIO_W'(DIV_RATIO_2);
            default:   ratio_of = RATIO_W'(DIV_RATIO_6);
        endcase
    endfunction

    assign tick      = cen && (cen_cnt == ratio - 1'b1);
    assign last_slot = (slot_cnt == SLOT_W'(SLOTS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt  <= '0;
            ratio    <= RATIO_W'(DIV_RATIO_6);
            slot_cnt <= '0;
            clk_en   <= 1'b0;
            zero     <= 1'b0;
        end else begin
            clk_en <= tick;
            zero   <= tick && last_slot;   // Rides on the closing clk_en
            if (tick) begin
                cen_cnt  <= '0;
                ratio    <= ratio_of(div_sel);  // Divider change lands here only
                slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;
            end else if (cen) begin
                cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

    // Zero marks the end of a slot cycle, so it must coincide with a clk_en
    assert property (@(posedge clk) disable iff (!arst_n) zero |-> clk_en)
        else $error("zero pulse without clk_en");

    assert property (@(posedge clk) disable iff (!arst_n) cen_cnt < ratio)
        else $error("cen counter passed the divider ratio");

endmodule

`default_nettype wire

// File: rtl/opn_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module opn_host_regs
    import opn_reg_pkg::*;
    import opn_clk_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clk_en,
    input  logic [7:0]       din,
    input  logic [1:0]       addr,
    input  logic             cs_n,
    input  logic             wr_n,
    output logic [7:0]       dout,
    output logic [DIV_W-1:0] div_sel,
    timer_ctrl_if.regs       tmr
);
    localparam int BUSY_W = $clog2(BUSY_TICKS);

    logic                    write;
    logic                    addr_wr;
    logic                    data_wr;
    logic                    ctl_wr;
    logic [7:0]              reg_addr;  // Last address written
    logic                    reg_bank;  // addr[1] of that address write
    logic [TA_W-TA_LO_W-1:0] ta_hi;
    logic [TA_LO_W-1:0]      ta_lo;
    logic [TB_W-1:0]         tb_val;
    logic                    busy;
    logic [BUSY_W-1:0]       busy_cnt;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];
    assign ctl_wr  = data_wr && !reg_bank && (reg_addr == REG_TIMER_CTL);

    assign tmr.value_a = {ta_hi, ta_lo};
    assign tmr.value_b = tb_val;

    // Address latch and prescaler select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_addr <= '0;
            reg_bank <= 1'b0;
            div_sel  <= DIV_SEL_6;
        end else if (addr_wr) begin
            reg_addr <= din;
            reg_bank <= addr[1];
            if (!addr[1]) begin
                case (din)
                    REG_DIV6: div_sel <= DIV_SEL_6;
                    REG_DIV3: div_sel <= DIV_SEL_3;
                    REG_DIV2: div_sel <= DIV_SEL_2;
                    default: ;
                endcase
            end
        end
    end

    // Timer registers live in bank 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ta_hi        <= '0;
            ta_lo        <= '0;
            tb_val       <= '0;
            tmr.load_a   <= 1'b0;
            tmr.load_b   <= 1'b0;
            tmr.irq_en_a <= 1'b0;
            tmr.irq_en_b <= 1'b0;
        end else if (data_wr && !reg_bank) begin
            case (reg_addr)
                REG_TA_HI: ta_hi  <= din;
                REG_TA_LO: ta_lo  <= din[TA_LO_W-1:0];
                REG_TB:    tb_val <= din;
                REG_TIMER_CTL: begin
                    tmr.load_a   <= din[CTL_LOAD_A_BIT];
                    tmr.load_b   <= din[CTL_LOAD_B_BIT];
                    tmr.irq_en_a <= din[CTL_IRQ_EN_A_BIT];
                    tmr.irq_en_b <= din[CTL_IRQ_EN_B_BIT];
                end
                default: ;
            endcase
        end
    end

    // Flag clear pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tmr.clr_a <= 1'b0;
            tmr.clr_b <= 1'b0;
        end else begin
            tmr.clr_a <= ctl_wr && din[CTL_CLR_A_BIT];
            tmr.clr_b <= ctl_wr && din[CTL_CLR_B_BIT];
        end
    end

    // Busy after any data write lasts BUSY_TICKS clk_en pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;    // Restart on every data write
            busy_cnt <= '0;
        end else if (busy && clk_en) begin
            if (busy_cnt == BUSY_W'(BUSY_TICKS - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    always_comb begin
        dout                    = 8'h00;
        dout[STATUS_BUSY_BIT]   = busy;
        dout[STATUS_FLAG_A_BIT] = tmr.flag_a;
        dout[STATUS_FLAG_B_BIT] = tmr.flag_b;
    end

    assert property (@(posedge clk) disable iff (!arst_n) tmr.clr_a |=> !tmr.clr_a)
        else $error("clr_a held for two clocks");

endmodule

`default_nettype wire

// File: rtl/opn_timer_counter.sv
`timescale 1ns/1ps
`default_nettype none

module opn_timer_counter #(
    parameter int WIDTH    = 10,
    parameter int PRESCALE = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             zero,
    input  logic [WIDTH-1:0] value,
    input  logic             load,
    input  logic             irq_en,
    input  logic             clr,
    output logic             flag
);
    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PRE_W-1:0] pre_cnt;
    logic             step;
    logic [WIDTH-1:0] cnt;
    logic             load_q;
    logic             start;     // Rising edge of load
    logic             wrap;

    assign step  = zero && (pre_cnt == PRE_W'(PRESCALE - 1));
    assign start = load && !load_q;
    assign wrap  = !start && load && step && (&cnt);

    // Free-running prescaler on zero pulses
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
        end else if (step) begin
            pre_cnt <= '0;
        end else if (zero) begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_q <= 1'b0;
            cnt    <= '0;
        end else begin
            load_q <= load;
            if (start || wrap) begin
                cnt <= value;        // Load and reload on overflow
            end else if (load && step) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (wrap && irq_en) begin
            flag <= 1'b1;            // Set beats a same-cycle clear
        end else if (clr) begin
            flag <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !irq_en |=> !$rose(flag))
        else $error("timer flag rose with irq disabled");

endmodule

`default_nettype wire

// File: rtl/opn_timers.sv
`timescale 1ns/1ps
`default_nettype none

module opn_timers
    import opn_reg_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         zero,
    timer_ctrl_if.timers tmr,
    output logic         irq_n
);

    // Timer A steps on every zero pulse
    opn_timer_counter #(
        .WIDTH    (TA_W),
        .PRESCALE (1)
    ) i_timer_a (
        .clk    (clk),
        .arst_n (arst_n),
        .zero   (zero),
        .value  (tmr.value_a),
        .load   (tmr.load_a),
        .irq_en (tmr.irq_en_a),
        .clr    (tmr.clr_a),
        .flag   (tmr.flag_a)
    );

    // Timer B is 16 times slower
    opn_timer_counter #(
        .WIDTH    (TB_W),
        .PRESCALE (TB_PRESCALE)
    ) i_timer_b (
        .clk    (clk),
        .arst_n (arst_n),
        .zero   (zero),
        .value  (tmr.value_b),
        .load   (tmr.load_b),
        .irq_en (tmr.irq_en_b),
        .clr    (tmr.clr_b),
        .flag   (tmr.flag_b)
    );

    assign irq_n = !(tmr.flag_a || tmr.flag_b);   // Active low, either flag

endmodule

`default_nettype wire

// File: rtl/opn_timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module opn_timer_top
    import opn_clk_pkg::*;
#(
    parameter int NUM_CH = 6
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);
    logic             clk_en;
    logic             zero;     // One pulse per full slot cycle
    logic [DIV_W-1:0] div_sel;

    timer_ctrl_if tmr_if ();

    opn_clock_gen #(
        .NUM_CH (NUM_CH)
    ) i_clock_gen (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en),
        .zero    (zero)
    );

    opn_host_regs i_host_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .clk_en  (clk_en),
        .din     (din),
        .addr    (addr),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .dout    (dout),
        .div_sel (div_sel),
        .tmr     (tmr_if.regs)
    );

    opn_timers i_timers (
        .clk    (clk),
        .arst_n (arst_n),
        .zero   (zero),
        .tmr    (tmr_if.timers),
        .irq_n  (irq_n)
    );

endmodule

`default_nettype wire

// File: dv/tb_opn_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_opn_timer
    import opn_reg_pkg::*;
    import opn_clk_pkg::*;
();
    localparam int NUM_CH = 6;
    localparam int SLOTS  = NUM_CH * OPS_PER_CH;

    // Timer control bytes
    localparam logic [7:0] CTL_STOP   = 8'((1 << CTL_CLR_A_BIT) | (1 << CTL_CLR_B_BIT));
    localparam logic [7:0] CTL_RUN_A  = 8'((1 << CTL_LOAD_A_BIT) | (1 << CTL_IRQ_EN_A_BIT));
    localparam logic [7:0] CTL_RUN_B  = 8'((1 << CTL_LOAD_B_BIT) | (1 << CTL_IRQ_EN_B_BIT));
    localparam logic [7:0] CTL_MASK_A = 8'(1 << CTL_LOAD_A_BIT);  // Counts, irq disabled

    logic       clk;
    logic       arst_n;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    logic [31:0] rng_state;
    int          ta_vals[4];
    int          tb_value;
    int          watchdog_clocks;
    int          error_count;

    // Hand-off to the period checker
    bit          measure_req;
    bit          measure_done;
    string       measure_name;
    int          measure_exp;
    int          measure_tol;

    opn_timer_top #(
        .NUM_CH (NUM_CH)
    ) i_opn_timer_top (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .dout   (dout),
        .irq_n  (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Clocks from load to overflow flag
    function automatic int expected_period(input int width, input int prescale,
                                           input int value, input int ratio);
        int steps;
        steps = (1 << width) - value;
        return steps * prescale * SLOTS * ratio;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_status(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("error %s: expected 8'h%02h, actual 8'h%02h",
                                name, expected, actual));
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("error %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_period(input string name, input int expected, input int actual,
                                input int tol);
        if (actual < expected - tol || actual > expected + tol) begin
            error_count++;
            abort_run($sformatf("error %s: expected %0d clocks (+/- %0d), actual %0d",
                                name, expected, tol, actual));
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the sampling edge
    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] data);
        bus_write(2'b00, reg_addr);
        bus_write(2'b01, data);
    endtask

    task automatic wait_not_busy(input string name);
        int clocks;
        clocks = 0;
        while (dout[STATUS_BUSY_BIT]) begin
            if (clocks > BUSY_TICKS * DIV_RATIO_6 + 6) begin
                error_count++;
                abort_run($sformatf("%s: busy did not drop after %0d clocks", name, clocks));
            end
            @(posedge clk);
            #1;
            clocks++;
        end
    endtask

    task automatic load_value(input bit use_b, input int value);
        if (use_b) begin
            write_reg(REG_TB, 8'(value));
        end else begin
            write_reg(REG_TA_HI, 8'(value >> 2));
            write_reg(REG_TA_LO, 8'(value & 3));
        end
    endtask

    task automatic run_timer(input string name, input bit use_b, input int value,
                             input int ratio);
        int         width;
        int         prescale;
        logic [7:0] exp_st;
        width    = use_b ? TB_W : TA_W;
        prescale = use_b ? TB_PRESCALE : 1;
        exp_st   = 8'h00;
        write_reg(REG_TIMER_CTL, CTL_STOP);
        load_value(use_b, value);
        measure_name = name;
        measure_exp  = expected_period(width, prescale, value, ratio);
        measure_tol  = prescale * SLOTS * ratio + 1;  // One step of phase plus sampling
        write_reg(REG_TIMER_CTL, use_b ? CTL_RUN_B : CTL_RUN_A);
        measure_done = 1'b0;
        measure_req  = 1'b1;
        wait (measure_done);
        exp_st[use_b ? STATUS_FLAG_B_BIT : STATUS_FLAG_A_BIT] = 1'b1;
        check_status({name, "_status"}, exp_st, dout);
    endtask

    task automatic clear_flag(input string name, input logic [7:0] ctl);
        write_reg(REG_TIMER_CTL, ctl);
        repeat (2) begin   // clr pulse, then the flag drops
            @(posedge clk);
            #1;
        end
        check_level({name, "_irq"}, 1'b1, irq_n);
        wait_not_busy(name);
        check_status({name, "_status"}, 8'h00, dout);
    endtask

    task automatic mask_test(input int value);
        int span;
        int n;
        span = 2 * expected_period(TA_W, 1, value, DIV_RATIO_6);
        write_reg(REG_TIMER_CTL, CTL_STOP);
        load_value(1'b0, value);
        write_reg(REG_TIMER_CTL, CTL_MASK_A);
        for (n = 0; n < span; n++) begin
            @(posedge clk);
            #1;
            check_level("mask_irq", 1'b1, irq_n);
        end
        check_status("mask_status", 8'h00, dout);
        write_reg(REG_TIMER_CTL, CTL_STOP);
    endtask

    // Counts clocks from the load write until irq_n is seen low
    initial begin : period_checker
        int clocks;
        logic irq_seen;
        forever begin
            wait (measure_req);
            clocks   = 0;
            irq_seen = 1'b0;
            while (!irq_seen) begin
                @(posedge clk);
                #1;
                clocks++;
                irq_seen = !irq_n;
            end
            check_period(measure_name, measure_exp, clocks, measure_tol);
            measure_req  = 1'b0;
            measure_done = 1'b1;
        end
    end

    initial begin : watchdog
        wait (watchdog_clocks > 0);
        repeat (watchdog_clocks) @(posedge clk);
        abort_run($sformatf("Timeout: tests still running after %0d clocks", watchdog_clocks));
    end

    initial begin : stimulus
        int ref_total;
        int i;
        arst_n          = 1'b0;
        cen             = 1'b1;
        din             = 8'h00;
        addr            = 2'b00;
        cs_n            = 1'b1;
        wr_n            = 1'b1;
        measure_req     = 1'b0;
        measure_done    = 1'b0;
        error_count     = 0;
        watchdog_clocks = 0;
        rng_state       = 32'hc1829d84;

        // 4 to 19 steps for timer A, 2 to 9 for timer B
        for (i = 0; i < 4; i++) begin
            rng_state  = xorshift32(rng_state);
            ta_vals[i] = (1 << TA_W) - 4 - int'(rng_state[3:0]);
        end
        rng_state = xorshift32(rng_state);
        tb_value  = (1 << TB_W) - 2 - int'(rng_state[2:0]);

        ref_total = expected_period(TA_W, 1, ta_vals[0], DIV_RATIO_6)
                  + expected_period(TB_W, TB_PRESCALE, tb_value, DIV_RATIO_6)
                  + 2 * expected_period(TA_W, 1, ta_vals[1], DIV_RATIO_6)
                  + expected_period(TA_W, 1, ta_vals[2], DIV_RATIO_2)
                  + expected_period(TA_W, 1, ta_vals[3], DIV_RATIO_3);
        watchdog_clocks = 2 * ref_total + 2000;

        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_status("reset_dout", 8'h00, dout);
        check_level("reset_irq", 1'b1, irq_n);

        write_reg(REG_TB, 8'h00);
        check_status("busy_set", 8'(1 << STATUS_BUSY_BIT), dout);
        wait_not_busy("busy_clear");
        check_status("busy_clear", 8'h00, dout);

        run_timer("timer_a", 1'b0, ta_vals[0], DIV_RATIO_6);
        clear_flag("clear_a", 8'(1 << CTL_CLR_A_BIT));
        run_timer("timer_b", 1'b1, tb_value, DIV_RATIO_6);
        clear_flag("clear_b", 8'(1 << CTL_CLR_B_BIT));
        mask_test(ta_vals[1]);

        bus_write(2'b00, REG_DIV2);
        repeat (2 * SLOTS * DIV_RATIO_6) @(posedge clk);  // Let the slot cycle settle
        #1;
        run_timer("timer_a_div2", 1'b0, ta_vals[2], DIV_RATIO_2);

        bus_write(2'b00, REG_DIV3);
        repeat (2 * SLOTS * DIV_RATIO_6) @(posedge clk);
        #1;
        run_timer("timer_a_div3", 1'b0, ta_vals[3], DIV_RATIO_3);

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/opn_reg_pkg.sv
rtl/opn_clk_pkg.sv
rtl/timer_ctrl_if.sv
rtl/opn_clock_gen.sv
rtl/opn_host_regs.sv
rtl/opn_timer_counter.sv
rtl/opn_timers.sv
rtl/opn_timer_top.sv
dv/tb_opn_timer.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_opn_timer -f tb.f -o tb_opn_timer_sim

status=0
./obj_dir/tb_opn_timer_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed (exit status $status)"
    exit 1
fi
